// File: rtl/cpc_glue_pkg.sv
`default_nettype none

package cpc_glue_pkg;

    // ----------------------------------------
    // ROM placement
    // ----------------------------------------
    localparam int unsigned ROM_SLOTS       = 4;       // OS, BASIC, AMSDOS, MF2
    localparam int unsigned ROM_INDEX_LIMIT = 4;       // Higher indices write nothing
    localparam logic [8:0]  OS_BANK         = 9'h000;
    localparam logic [8:0]  BASIC_BANK      = 9'h100;  // Upper ROM 0
    localparam logic [8:0]  AMSDOS_BANK     = 9'h107;  // Upper ROM 7
    localparam logic [8:0]  MF2_BANK        = 9'h0FF;

    // ----------------------------------------
    // Multiface Two
    // ----------------------------------------
    localparam logic [15:0] MF2_NMI_VECTOR   = 16'h0066;
    localparam logic [15:0] MF2_HIDE_ADDR    = 16'h0065;
    localparam logic [13:0] MF2_CTRL_PORT_HI = 14'h3FBA;  // FEE8..FEEB

    // Shadow store locations inside MF2 RAM
    localparam logic [12:0] ST_PEN          = 13'h1FCF;
    localparam logic [12:0] ST_BORDER       = 13'h1FDF;
    localparam logic [12:0] ST_PALETTE_BASE = 13'h1F90;
    localparam logic [12:0] ST_MODE         = 13'h1FEF;
    localparam logic [12:0] ST_BANK         = 13'h1FFF;
    localparam logic [12:0] ST_CRTC_SEL     = 13'h1CFF;
    localparam logic [12:0] ST_CRTC_BASE    = 13'h1DB0;
    localparam logic [12:0] ST_PPI          = 13'h17FF;
    localparam logic [12:0] ST_ROM_SEL      = 13'h1AAC;

    // I/O port high bytes
    localparam logic [7:0] GA_PORT        = 8'h7F;
    localparam logic [7:0] CRTC_SEL_PORT  = 8'hBC;
    localparam logic [7:0] CRTC_DATA_PORT = 8'hBD;
    localparam logic [7:0] PPI_PORT       = 8'hF7;
    localparam logic [7:0] ROM_SEL_PORT   = 8'hDF;

    // ----------------------------------------
    // Buses
    // ----------------------------------------
    typedef struct packed {
        logic        download;
        logic        wr;
        logic [7:0]  index;
        logic [24:0] addr;
        logic [7:0]  dout;
    } ioctl_t;

    typedef struct packed {
        logic [22:0] addr;
        logic [7:0]  data;
    } mem_wr_t;

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  dout;
        logic        m1;
        logic        iorq;
        logic        rd;
        logic        wr;
        logic        mem_rd;
        logic        mem_wr;
    } cpu_bus_t;

    typedef struct packed {
        logic        we;
        logic [12:0] addr;
        logic [7:0]  data;
    } mf2_ram_wr_t;

    typedef enum logic [1:0] {
        LD_IDLE,
        LD_REQ,      // mem_req high, waiting for ack
        LD_RELEASE   // req dropped, waiting for ack low
    } loader_state_e;

    typedef enum logic [2:0] {
        MF2_OFF,
        MF2_NMI_PENDING,
        MF2_ACTIVE,
        MF2_ACTIVE_HIDDEN,
        MF2_OFF_HIDDEN
    } mf2_state_e;

    typedef enum logic [3:0] {
        PORT_NONE,
        PORT_GA_PEN,
        PORT_GA_COLOR,
        PORT_GA_MODE,
        PORT_GA_BANK,
        PORT_CRTC_SEL,
        PORT_CRTC_DATA,
        PORT_PPI,
        PORT_ROM_SEL
    } hw_port_e;

endpackage

`default_nettype wire

// File: rtl/download_loader.sv
`default_nettype none

module download_loader (
    input  logic                  clk_48,
    input  logic                  reset,
    input  cpc_glue_pkg::ioctl_t  ioctl,
    output logic                  ioctl_wait,
    output logic                  mem_req,
    input  logic                  mem_ack,
    output cpc_glue_pkg::mem_wr_t mem_wr,
    output logic [255:0]          rom_map,
    output logic                  rom_loaded,
    output logic                  core_reset
);

    cpc_glue_pkg::loader_state_e state;

    logic [10:0] slot;        // 16 KB slot within the image
    logic [8:0]  bank;        // Target bank in external memory
    logic        rom_index;
    logic        slot_ok;
    logic        accept;
    logic        download_q;  // Previous download level

    // ----------------------------------------
    // Decode
    // ----------------------------------------
    assign slot      = ioctl.addr[24:14];
    assign rom_index = ioctl.index[4:0] < 5'(cpc_glue_pkg::ROM_INDEX_LIMIT);
    assign slot_ok   = slot < 11'(cpc_glue_pkg::ROM_SLOTS);

    // Only one byte in flight, host waits on ioctl_wait
    assign accept = ioctl.download & ioctl.wr & rom_index & slot_ok
                    & (state == cpc_glue_pkg::LD_IDLE);

    always_comb begin
        case (slot[1:0])
            2'd0:    bank = cpc_glue_pkg::OS_BANK;
            2'd1:    bank = cpc_glue_pkg::BASIC_BANK;
            2'd2:    bank = cpc_glue_pkg::AMSDOS_BANK;
            default: bank = cpc_glue_pkg::MF2_BANK;
        endcase
    end

    // ----------------------------------------
    // Four-phase write handshake
    // ----------------------------------------
    always_ff @(posedge clk_48) begin
        if (reset) begin
            state <= cpc_glue_pkg::LD_IDLE;
        end else begin
            case (state)
                cpc_glue_pkg::LD_IDLE: begin
                    if (accept) begin
                        state <= cpc_glue_pkg::LD_REQ;
                    end
                end
                cpc_glue_pkg::LD_REQ: begin
                    if (mem_ack) begin
                        state <= cpc_glue_pkg::LD_RELEASE;  // Drop req next
                    end
                end
                cpc_glue_pkg::LD_RELEASE: begin
                    if (!mem_ack) begin
                        state <= cpc_glue_pkg::LD_IDLE;
                    end
                end
                default: state <= cpc_glue_pkg::LD_IDLE;
            endcase
        end
    end

    assign mem_req    = (state == cpc_glue_pkg::LD_REQ);
    assign ioctl_wait = (state != cpc_glue_pkg::LD_IDLE);  // Covers whole handshake

    // Address and data held for the whole transfer
    always_ff @(posedge clk_48) begin
        if (accept) begin
            mem_wr.addr <= {bank, ioctl.addr[13:0]};
            mem_wr.data <= ioctl.dout;
        end
    end

    // ----------------------------------------
    // Upper ROM map and core reset
    // ----------------------------------------
    always_ff @(posedge clk_48) begin
        if (reset) begin
            rom_map <= '0;
        end else if (accept && bank[8]) begin
            rom_map[bank[7:0]] <= 1'b1;  // BASIC bit 0, AMSDOS bit 7
        end
    end

    always_ff @(posedge clk_48) begin
        if (reset) begin
            download_q <= 1'b0;
            rom_loaded <= 1'b0;
            core_reset <= 1'b1;  // Core held until first image is in
        end else begin
            download_q <= ioctl.download;
            if (download_q && !ioctl.download) begin  // End of download
                rom_loaded <= 1'b1;
                core_reset <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/mf2_controller.sv
`default_nettype none

module mf2_controller (
    input  logic                      clk_48,
    input  logic                      reset,
    input  logic                      core_reset,
    input  cpc_glue_pkg::cpu_bus_t    cpu,
    input  logic                      key_nmi,
    output logic                      mf2_nmi,
    output logic                      mf2_rom_en,
    output logic                      mf2_ram_en,
    output cpc_glue_pkg::mf2_ram_wr_t ram_wr,
    output logic [12:0]               ram_rd_addr,
    output logic                      ram_sel
);

    cpc_glue_pkg::mf2_state_e state;
    cpc_glue_pkg::hw_port_e   port_op;

    logic        io_wr;
    logic        m1_q, io_wr_q, key_q;  // Previous samples
    logic        m1_edge, io_edge, key_edge;
    logic        ctrl_port;             // FEE8..FEEB
    logic        shadow_hit;
    logic        cpu_ram_wr;
    logic        mf2_active;
    logic [12:0] store_addr;
    logic [4:0]  pen_idx;               // Last GA pen select
    logic [3:0]  crtc_reg;              // Last CRTC register select
    logic        ram_we;
    logic [12:0] ram_addr_q;
    logic [7:0]  ram_data_q;

    assign io_wr    = cpu.wr & cpu.iorq;
    assign m1_edge  = cpu.m1 & ~m1_q;
    assign io_edge  = io_wr & ~io_wr_q;
    assign key_edge = key_nmi & ~key_q;

    assign ctrl_port  = (cpu.addr[15:2] == cpc_glue_pkg::MF2_CTRL_PORT_HI);
    assign shadow_hit = io_edge & ~ctrl_port & (port_op != cpc_glue_pkg::PORT_NONE);
    assign cpu_ram_wr = cpu.mem_wr & mf2_ram_en;

    // ----------------------------------------
    // Hardware port decode
    // ----------------------------------------
    always_comb begin
        case (cpu.addr[15:8])
            cpc_glue_pkg::GA_PORT: begin
                case (cpu.dout[7:6])  // GA function in top bits
                    2'b00:   port_op = cpc_glue_pkg::PORT_GA_PEN;
                    2'b01:   port_op = cpc_glue_pkg::PORT_GA_COLOR;
                    2'b10:   port_op = cpc_glue_pkg::PORT_GA_MODE;
                    default: port_op = cpc_glue_pkg::PORT_GA_BANK;
                endcase
            end
            cpc_glue_pkg::CRTC_SEL_PORT:  port_op = cpc_glue_pkg::PORT_CRTC_SEL;
            cpc_glue_pkg::CRTC_DATA_PORT: port_op = cpc_glue_pkg::PORT_CRTC_DATA;
            cpc_glue_pkg::PPI_PORT:       port_op = cpc_glue_pkg::PORT_PPI;
            cpc_glue_pkg::ROM_SEL_PORT:   port_op = cpc_glue_pkg::PORT_ROM_SEL;
            default:                      port_op = cpc_glue_pkg::PORT_NONE;
        endcase
    end

    always_comb begin
        case (port_op)
            cpc_glue_pkg::PORT_GA_PEN:    store_addr = cpc_glue_pkg::ST_PEN;
            cpc_glue_pkg::PORT_GA_COLOR:  store_addr = pen_idx[4] ? cpc_glue_pkg::ST_BORDER
                                              : cpc_glue_pkg::ST_PALETTE_BASE + 13'(pen_idx[3:0]);
            cpc_glue_pkg::PORT_GA_MODE:   store_addr = cpc_glue_pkg::ST_MODE;
            cpc_glue_pkg::PORT_GA_BANK:   store_addr = cpc_glue_pkg::ST_BANK;
            cpc_glue_pkg::PORT_CRTC_SEL:  store_addr = cpc_glue_pkg::ST_CRTC_SEL;
            cpc_glue_pkg::PORT_CRTC_DATA: store_addr = cpc_glue_pkg::ST_CRTC_BASE + 13'(crtc_reg);
            cpc_glue_pkg::PORT_PPI:       store_addr = cpc_glue_pkg::ST_PPI;
            cpc_glue_pkg::PORT_ROM_SEL:   store_addr = cpc_glue_pkg::ST_ROM_SEL;
            default:                      store_addr = 13'h0000;
        endcase
    end

    // ----------------------------------------
    // State machine
    // ----------------------------------------
    always_ff @(posedge clk_48) begin
        if (reset || core_reset) begin
            state <= cpc_glue_pkg::MF2_OFF;
        end else begin
            case (state)
                cpc_glue_pkg::MF2_OFF, cpc_glue_pkg::MF2_OFF_HIDDEN: begin
                    if (key_edge) begin
                        state <= cpc_glue_pkg::MF2_NMI_PENDING;  // Freeze button
                    end else if (io_edge && ctrl_port && !cpu.addr[1]
                                 && state == cpc_glue_pkg::MF2_OFF) begin
                        state <= cpc_glue_pkg::MF2_ACTIVE;  // Enable refused when hidden
                    end
                end
                cpc_glue_pkg::MF2_NMI_PENDING: begin
                    if (m1_edge && cpu.addr == cpc_glue_pkg::MF2_NMI_VECTOR) begin
                        state <= cpc_glue_pkg::MF2_ACTIVE;  // Page in, hidden flag gone
                    end
                end
                cpc_glue_pkg::MF2_ACTIVE: begin
                    if (m1_edge && cpu.addr == cpc_glue_pkg::MF2_HIDE_ADDR) begin
                        state <= cpc_glue_pkg::MF2_ACTIVE_HIDDEN;
                    end else if (io_edge && ctrl_port && cpu.addr[1]) begin
                        state <= cpc_glue_pkg::MF2_OFF;
                    end
                end
                cpc_glue_pkg::MF2_ACTIVE_HIDDEN: begin
                    if (io_edge && ctrl_port) begin
                        state <= cpc_glue_pkg::MF2_OFF_HIDDEN;  // Either port turns it off
                    end
                end
                default: state <= cpc_glue_pkg::MF2_OFF;
            endcase
        end
    end

    // Edge samples, register tracking and write strobe
    always_ff @(posedge clk_48) begin
        if (reset || core_reset) begin
            m1_q     <= 1'b0;
            io_wr_q  <= 1'b0;
            key_q    <= 1'b0;
            pen_idx  <= '0;
            crtc_reg <= '0;
            ram_we   <= 1'b0;
        end else begin
            m1_q    <= cpu.m1;
            io_wr_q <= io_wr;
            key_q   <= key_nmi;
            if (shadow_hit && port_op == cpc_glue_pkg::PORT_GA_PEN) begin
                pen_idx <= cpu.dout[4:0];
            end
            if (shadow_hit && port_op == cpc_glue_pkg::PORT_CRTC_SEL) begin
                crtc_reg <= cpu.dout[3:0];
            end
            ram_we <= shadow_hit | cpu_ram_wr;
        end
    end

    // Shadow store wins over a plain RAM write
    always_ff @(posedge clk_48) begin
        ram_addr_q <= shadow_hit ? store_addr : cpu.addr[12:0];
        ram_data_q <= cpu.dout;
    end

    // ----------------------------------------
    // Outputs
    // ----------------------------------------
    assign mf2_active = (state == cpc_glue_pkg::MF2_ACTIVE)
                        | (state == cpc_glue_pkg::MF2_ACTIVE_HIDDEN);
    assign mf2_nmi    = (state == cpc_glue_pkg::MF2_NMI_PENDING);
    assign mf2_rom_en = mf2_active & (cpu.addr[15:13] == 3'b000);  // 0000..1FFF
    assign mf2_ram_en = mf2_active & (cpu.addr[15:13] == 3'b001);  // 2000..3FFF

    assign ram_wr.we   = ram_we;
    assign ram_wr.addr = ram_addr_q;
    assign ram_wr.data = ram_data_q;
    assign ram_rd_addr = cpu.addr[12:0];
    assign ram_sel     = mf2_ram_en;

endmodule

`default_nettype wire

// File: rtl/mf2_ram.sv
`default_nettype none

module mf2_ram (
    input  logic                      clk_48,
    input  cpc_glue_pkg::mf2_ram_wr_t ram_wr,
    input  logic [12:0]               ram_rd_addr,
    input  logic                      ram_sel,
    input  logic                      mem_rd,
    output logic [7:0]                mf2_dout
);

    logic [7:0]  mem [8192];   // 8 KB RAM
    logic [12:0] rd_addr_q;
    logic [7:0]  rd_data_q;
    logic [1:0]  rd_sel_q;     // Read enable pipe, matches data path

    always_ff @(posedge clk_48) begin
        if (ram_wr.we) begin
            mem[ram_wr.addr] <= ram_wr.data;
        end
    end

    // Address then data registered
    always_ff @(posedge clk_48) begin
        rd_addr_q <= ram_rd_addr;
        rd_data_q <= mem[rd_addr_q];
        rd_sel_q  <= {rd_sel_q[0], ram_sel & mem_rd};
    end

    // Open bus reads as FF, ANDed into CPU data outside
    assign mf2_dout = (rd_sel_q[1] && ram_sel && mem_rd) ? rd_data_q : 8'hFF;

endmodule

`default_nettype wire

// File: rtl/cpc_glue_top.sv
`default_nettype none

module cpc_glue_top (
    input  logic                   clk_48,
    input  logic                   reset,
    // Host download
    input  cpc_glue_pkg::ioctl_t   ioctl,
    output logic                   ioctl_wait,
    // External memory
    output logic                   mem_req,
    input  logic                   mem_ack,
    output cpc_glue_pkg::mem_wr_t  mem_wr,
    // Core side
    output logic [255:0]           rom_map,
    output logic                   rom_loaded,
    output logic                   core_reset,
    input  cpc_glue_pkg::cpu_bus_t cpu,
    input  logic                   key_nmi,
    output logic                   mf2_nmi,
    output logic                   mf2_rom_en,
    output logic                   mf2_ram_en,
    output logic [7:0]             mf2_dout
);

    cpc_glue_pkg::mf2_ram_wr_t ram_wr;
    logic [12:0]               ram_rd_addr;
    logic                      ram_sel;

    // ----------------------------------------
    // Firmware loader
    // ----------------------------------------
    download_loader download_loader_i (
        .clk_48     (clk_48),
        .reset      (reset),
        .ioctl      (ioctl),
        .ioctl_wait (ioctl_wait),
        .mem_req    (mem_req),
        .mem_ack    (mem_ack),
        .mem_wr     (mem_wr),
        .rom_map    (rom_map),
        .rom_loaded (rom_loaded),
        .core_reset (core_reset)
    );

    // ----------------------------------------
    // Multiface Two
    // ----------------------------------------
    mf2_controller mf2_controller_i (
        .clk_48      (clk_48),
        .reset       (reset),
        .core_reset  (core_reset),   // MF2 follows core reset
        .cpu         (cpu),
        .key_nmi     (key_nmi),
        .mf2_nmi     (mf2_nmi),
        .mf2_rom_en  (mf2_rom_en),
        .mf2_ram_en  (mf2_ram_en),
        .ram_wr      (ram_wr),
        .ram_rd_addr (ram_rd_addr),
        .ram_sel     (ram_sel)
    );

    mf2_ram mf2_ram_i (
        .clk_48      (clk_48),
        .ram_wr      (ram_wr),
        .ram_rd_addr (ram_rd_addr),
        .ram_sel     (ram_sel),
        .mem_rd      (cpu.mem_rd),
        .mf2_dout    (mf2_dout)
    );

endmodule

`default_nettype wire

// File: verification/clock_reset_gen.sv
`default_nettype none

module clock_reset_gen (
    output logic clk_48,
    output logic reset
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 10;

    initial begin
        clk_48 = 1'b0;
        forever #10 clk_48 = ~clk_48;  // 20 ns period
    end

    // Released on a falling edge, away from the sampling edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_48);
        @(negedge clk_48);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// File: verification/mf2_properties.sv
`default_nettype none

module mf2_properties (
    input logic        clk_48,
    input logic        reset,
    input logic        mem_req,
    input logic        mem_ack,
    input logic [30:0] mem_wr,
    input logic        mf2_rom_en,
    input logic        mf2_ram_en
);

    timeunit 1ns;
    timeprecision 1ps;

    // ----------------------------------------
    // Memory handshake
    // ----------------------------------------
    wr_stable_a: assert property (@(posedge clk_48) disable iff (reset)
        (mem_req && !mem_ack) |=> $stable(mem_wr))
        else $error("mem_wr changed while waiting for mem_ack");

    // New request only once the previous ack is gone
    req_after_ack_a: assert property (@(posedge clk_48) disable iff (reset)
        $rose(mem_req) |-> !mem_ack)
        else $error("mem_req rose while mem_ack high");

    // ----------------------------------------
    // MF2 windows
    // ----------------------------------------
    window_excl_a: assert property (@(posedge clk_48) disable iff (reset)
        !(mf2_rom_en && mf2_ram_en))
        else $error("mf2_rom_en and mf2_ram_en both high");

endmodule

// Loader side, MF2 inputs tied off
bind download_loader mf2_properties loader_props_i (
    .clk_48     (clk_48),
    .reset      (reset),
    .mem_req    (mem_req),
    .mem_ack    (mem_ack),
    .mem_wr     (mem_wr),
    .mf2_rom_en (1'b0),
    .mf2_ram_en (1'b0)
);

// MF2 side, handshake inputs tied off
bind mf2_controller mf2_properties mf2_props_i (
    .clk_48     (clk_48),
    .reset      (reset),
    .mem_req    (1'b0),
    .mem_ack    (1'b0),
    .mem_wr     (31'd0),
    .mf2_rom_en (mf2_rom_en),
    .mf2_ram_en (mf2_ram_en)
);

`default_nettype wire

// File: verification/cpc_glue_tb.sv
`default_nettype none

module cpc_glue_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_BYTES     = 150;
    localparam int N_SHADOW    = 60;
    localparam int N_RAM       = 40;
    localparam int STIM_CYCLES = 320 + N_BYTES * 10 + (N_SHADOW + N_RAM) * 8;
    localparam int TIMEOUT     = 4 * STIM_CYCLES;

    logic clk_48, gen_reset, tb_reset, reset;
    cpc_glue_pkg::ioctl_t   ioctl;
    cpc_glue_pkg::mem_wr_t  mem_wr;
    cpc_glue_pkg::cpu_bus_t cpu;
    logic         ioctl_wait, mem_req, mem_ack, key_nmi;
    logic [255:0] rom_map, map_model;
    logic         rom_loaded, core_reset, mf2_nmi, mf2_rom_en, mf2_ram_en;
    logic [7:0]   mf2_dout;

    logic [30:0] exp_q[$];           // Expected memory writes in order
    logic [30:0] got_q[$];           // Writes seen by the responder
    logic [7:0]  shadow_mem [8192];  // MF2 RAM model
    logic [4:0]  pen_model;
    logic [3:0]  crtc_model;
    int          ack_delay, cycle_count, check_count, error_count;

    assign reset = gen_reset | tb_reset;

    clock_reset_gen clock_reset_gen_i (.clk_48(clk_48), .reset(gen_reset));

    cpc_glue_top cpc_glue_top_i (
        .clk_48(clk_48), .reset(reset), .ioctl(ioctl), .ioctl_wait(ioctl_wait),
        .mem_req(mem_req), .mem_ack(mem_ack), .mem_wr(mem_wr),
        .rom_map(rom_map), .rom_loaded(rom_loaded), .core_reset(core_reset),
        .cpu(cpu), .key_nmi(key_nmi), .mf2_nmi(mf2_nmi), .mf2_rom_en(mf2_rom_en),
        .mf2_ram_en(mf2_ram_en), .mf2_dout(mf2_dout)
    );

    // ----------------------------------------
    // Memory responder and watchdog
    // ----------------------------------------
    always @(negedge clk_48) begin
        if (mem_req && !mem_ack) begin
            if (ack_delay == 0) begin
                ack_delay = $urandom_range(1, 4);  // Random ack latency
            end else begin
                ack_delay = ack_delay - 1;
                if (ack_delay == 0) begin
                    mem_ack = 1'b1;
                    got_q.push_back(mem_wr);  // Captured when acknowledged
                end
            end
        end else if (!mem_req && mem_ack) begin
            mem_ack = 1'b0;
        end
    end

    always @(posedge clk_48) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("Testbench failed");
            $finish;
        end
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    task automatic tick();
        @(negedge clk_48);
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        check_count = check_count + 1;
        if (actual !== expected) begin
            error_count = error_count + 1;
            $display("[ERROR] %0t: %s, got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    function automatic logic [8:0] bank_of(input logic [1:0] slot);
        case (slot)
            2'd0:    return 9'h000;  // OS6128
            2'd1:    return 9'h100;  // BASIC, upper ROM 0
            2'd2:    return 9'h107;  // AMSDOS, upper ROM 7
            default: return 9'h0FF;  // MF2
        endcase
    endfunction

    // One host byte then wait out the back-pressure
    task automatic send_byte(input logic [7:0] index, input logic [24:0] addr,
                             input logic [7:0] data);
        logic [8:0] bank;
        ioctl.index = index;
        ioctl.addr  = addr;
        ioctl.dout  = data;
        ioctl.wr    = 1'b1;
        if (index[4:0] < 5'd4 && addr[24:14] < 11'd4) begin
            bank = bank_of(addr[15:14]);
            exp_q.push_back({bank, addr[13:0], data});
            if (bank[8]) map_model[bank[7:0]] = 1'b1;
        end
        tick();
        ioctl.wr = 1'b0;
        tick();
        while (ioctl_wait) tick();
    endtask

    task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
        cpu.addr = addr;
        cpu.dout = data;
        cpu.iorq = 1'b1;
        cpu.wr   = 1'b1;
        tick();
        cpu.iorq = 1'b0;
        cpu.wr   = 1'b0;
        tick();
        tick();
    endtask

    task automatic fetch_m1(input logic [15:0] addr);
        cpu.addr = addr;
        cpu.m1   = 1'b1;
        tick();
        cpu.m1 = 1'b0;
        tick();
    endtask

    task automatic press_key();
        key_nmi = 1'b1;
        tick();
        key_nmi = 1'b0;
        tick();
    endtask

    task automatic probe_window(input logic [15:0] addr, input logic rom_exp,
                                input logic ram_exp, input string what);
        cpu.addr = addr;
        tick();
        check_value({31'd0, mf2_rom_en}, {31'd0, rom_exp}, {what, " rom_en"});
        check_value({31'd0, mf2_ram_en}, {31'd0, ram_exp}, {what, " ram_en"});
    endtask

    // Data is valid two cycles after the address
    task automatic read_check(input logic [15:0] addr, input logic [7:0] expected);
        cpu.addr   = addr;
        cpu.mem_rd = 1'b1;
        tick();
        tick();
        check_value({24'd0, mf2_dout}, {24'd0, expected}, "mf2_dout");
        cpu.mem_rd = 1'b0;
    endtask

    // Shadow store rules give the store address
    function automatic logic [12:0] shadow_model(input logic [15:0] a, input logic [7:0] d);
        logic [12:0] st;
        case (a[15:8])
            8'h7F: begin
                case (d[7:6])
                    2'b00: begin
                        st = cpc_glue_pkg::ST_PEN;
                        pen_model = d[4:0];
                    end
                    2'b01:   st = pen_model[4] ? cpc_glue_pkg::ST_BORDER
                                  : cpc_glue_pkg::ST_PALETTE_BASE + {9'd0, pen_model[3:0]};
                    2'b10:   st = cpc_glue_pkg::ST_MODE;
                    default: st = cpc_glue_pkg::ST_BANK;
                endcase
            end
            8'hBC: begin
                st = cpc_glue_pkg::ST_CRTC_SEL;
                crtc_model = d[3:0];
            end
            8'hBD:   st = cpc_glue_pkg::ST_CRTC_BASE + {9'd0, crtc_model};
            8'hF7:   st = cpc_glue_pkg::ST_PPI;
            default: st = cpc_glue_pkg::ST_ROM_SEL;
        endcase
        shadow_mem[st] = d;
        return st;
    endfunction

    task automatic compare_map();
        for (int i = 0; i < 8; i++) begin
            check_value(rom_map[i*32 +: 32], map_model[i*32 +: 32], "rom_map word");
        end
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin
        logic [31:0] r;
        logic [7:0]  idx, data;
        logic [15:0] port;
        logic [12:0] st;

        void'($urandom(32'hcc18_8f74));
        ioctl       = '0;  // All DUT inputs idle
        cpu         = '0;
        mem_ack     = 1'b0;
        key_nmi     = 1'b0;
        tb_reset    = 1'b0;
        map_model   = '0;
        pen_model   = '0;
        crtc_model  = '0;
        ack_delay   = 0;
        cycle_count = 0;
        check_count = 0;
        error_count = 0;
        @(negedge gen_reset);
        tick();
        check_value({31'd0, core_reset}, 32'd1, "core_reset after reset");

        // Random ROM download
        ioctl.download = 1'b1;
        tick();
        for (int n = 0; n < N_BYTES; n++) begin
            r   = $urandom;
            idx = r[0] ? {6'd0, r[2:1]} : r[15:8];  // Bias toward ROM indices
            send_byte(idx, {8'd0, r[18:16], r[31:18]}, r[27:20]);
        end
        ioctl.download = 1'b0;
        tick();
        tick();
        check_value(got_q.size(), exp_q.size(), "memory write count");
        while (exp_q.size() > 0 && got_q.size() > 0) begin
            check_value({1'b0, got_q.pop_front()}, {1'b0, exp_q.pop_front()}, "memory write");
        end
        check_value({31'd0, rom_loaded}, 32'd1, "rom_loaded");
        check_value({31'd0, core_reset}, 32'd0, "core_reset");
        compare_map();

        // NMI entry and control ports
        press_key();
        check_value({31'd0, mf2_nmi}, 32'd1, "mf2_nmi after key");
        fetch_m1(cpc_glue_pkg::MF2_NMI_VECTOR);
        check_value({31'd0, mf2_nmi}, 32'd0, "mf2_nmi after vector");
        probe_window(16'h1000, 1'b1, 1'b0, "active 1000");
        probe_window(16'h2800, 1'b0, 1'b1, "active 2800");
        probe_window(16'h4000, 1'b0, 1'b0, "active 4000");
        io_write(16'hFEEA, 8'h00);
        probe_window(16'h0100, 1'b0, 1'b0, "disabled");
        io_write(16'hFEE8, 8'h00);
        probe_window(16'h0100, 1'b1, 1'b0, "enabled");

        // Hidden MF2 refuses enable
        fetch_m1(cpc_glue_pkg::MF2_HIDE_ADDR);
        probe_window(16'h0100, 1'b1, 1'b0, "hidden active");
        io_write(16'hFEEA, 8'h00);
        probe_window(16'h0100, 1'b0, 1'b0, "hidden disable");
        io_write(16'hFEE8, 8'h00);
        probe_window(16'h0100, 1'b0, 1'b0, "hidden enable");
        press_key();
        fetch_m1(cpc_glue_pkg::MF2_NMI_VECTOR);
        io_write(16'hFEEA, 8'h00);
        io_write(16'hFEE8, 8'h00);
        probe_window(16'h0100, 1'b1, 1'b0, "hidden cleared");

        // Shadowed port writes
        for (int n = 0; n < N_SHADOW; n++) begin
            r = $urandom;
            case (r[2:0] % 5)
                0:       port = {8'h7F, r[15:8]};
                1:       port = {8'hBC, r[15:8]};
                2:       port = {8'hBD, r[15:8]};
                3:       port = {8'hF7, r[15:8]};
                default: port = {8'hDF, r[15:8]};
            endcase
            data = r[23:16];
            st   = shadow_model(port, data);
            io_write(port, data);
            read_check({3'b001, st}, shadow_mem[st]);
            if (r[31]) read_check({2'b01, r[29:16]}, 8'hFF);  // Outside the window
        end

        // CPU writes into MF2 RAM
        for (int n = 0; n < N_RAM; n++) begin
            r = $urandom;
            cpu.addr   = {3'b001, r[12:0]};
            cpu.dout   = r[23:16];
            cpu.mem_wr = 1'b1;
            shadow_mem[r[12:0]] = r[23:16];
            tick();
            cpu.mem_wr = 1'b0;
            tick();
            read_check({3'b001, r[12:0]}, shadow_mem[r[12:0]]);
        end

        // Reset clears loader outputs
        tb_reset = 1'b1;
        tick();
        tick();
        tb_reset = 1'b0;
        map_model = '0;
        check_value({31'd0, rom_loaded}, 32'd0, "rom_loaded after reset");
        check_value({31'd0, core_reset}, 32'd1, "core_reset after reset");
        compare_map();

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
rtl/cpc_glue_pkg.sv
rtl/download_loader.sv
rtl/mf2_controller.sv
rtl/mf2_ram.sv
rtl/cpc_glue_top.sv
verification/clock_reset_gen.sv
verification/mf2_properties.sv
verification/cpc_glue_tb.sv

// File: Makefile
# Verilator flow for the CPC glue logic

TOP = cpc_glue_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@grep -q "Testbench passed" $(LOG) || (echo "No pass result in log"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
